// ==== source/sd_cmd_pkg.sv ====
// Shared constants, codes and CRC7 helpers for the SD command-line engine
// Only short (48-bit, R1-class) responses are described here
package sd_cmd_pkg;

	// Frame length, command and response alike
	localparam int FRAME_BITS = 48;

	// x^7 + x^3 + 1
	localparam logic [6:0] CRC_POLY = 7'h09;

	// Response types, any nonzero type behaves as R1
	localparam logic [1:0] RT_NONE = 2'b00;
	localparam logic [1:0] RT_R1   = 2'b01;

	// Completion codes
	localparam logic [1:0] EC_TIMEOUT  = 2'b00;
	localparam logic [1:0] EC_OKAY     = 2'b01;
	localparam logic [1:0] EC_BADCRC   = 2'b10;
	localparam logic [1:0] EC_FRAMEERR = 2'b11;

	// Response fields, first received bit at the top
	typedef struct packed {
		logic        start;
		logic        transmission;
		logic [5:0]  index;
		logic [31:0] arg;
		logic [6:0]  crc;
		logic        stop;
	} resp_fields_t;

	// Raw view fills as a shift register, field view decodes it
	typedef union packed {
		logic [47:0]  raw;
		resp_fields_t f;
	} resp_word_u;

	// One CRC7 step, one bit in
	function automatic logic [6:0] crc7_step(input logic [6:0] fill, input logic bit_in);
		logic fb;
		fb = fill[6] ^ bit_in;
		return {fill[5:0], 1'b0} ^ (fb ? CRC_POLY : 7'h00);
	endfunction

	// CRC7 over start, command and argument, MSB first
	function automatic logic [6:0] crc7_40(input logic [39:0] bits);
		logic [6:0] fill;
		fill = 7'h00;
		for (int i = 39; i >= 0; i--)
			fill = crc7_step(fill, bits[i]);
		return fill;
	endfunction

endpackage

// ==== source/cmd_status_if.sv ====
// End-of-response report from the receiver to the sequencer
// resp_end and timed_out are single-cycle pulses and never coincide
interface cmd_status_if;

	// Pulses the cycle after the 48th response bit lands
	logic resp_end;

	// Check results, meaningful only alongside resp_end
	logic crc_bad;
	logic frame_bad;

	// Silent line, counter ran out before the last bit
	logic timed_out;

	// Receiver side
	modport report (
		output resp_end, crc_bad, frame_bad, timed_out
	);

	// Sequencer side
	modport judge (
		input resp_end, crc_bad, frame_bad, timed_out
	);

endinterface

// ==== source/cmd_tx.sv ====
// Command frame serializer, MSB first, advancing only on clock-enable cycles
// i_start is expected only while idle, and on a cycle with i_ckstb
module cmd_tx (
	input  logic        i_clk,
	input  logic        i_reset,
	input  logic        i_ckstb,
	input  logic        i_start,
	input  logic        i_cfg_dbl,
	input  logic [6:0]  i_cmd,
	input  logic [31:0] i_arg,
	output logic        o_cmd_en,
	output logic [1:0]  o_cmd_data,
	output logic        o_last,
	output logic        o_active
);
	import sd_cmd_pkg::*;

	logic        active;
	logic        dbl;
	logic [5:0]  remain;
	logic [5:0]  step;
	logic [47:0] sreg;

	// Bits consumed per strobe
	assign step = dbl ? 6'd2 : 6'd1;

	// Bit counter and line enable
	always_ff @(posedge i_clk)
	if (i_reset)
	begin
		active <= 1'b0;
		remain <= 6'd0;
		dbl    <= 1'b0;
	end else if (i_start)
	begin
		active <= 1'b1;
		remain <= 6'(FRAME_BITS);
		dbl    <= i_cfg_dbl;
	end else if (i_ckstb && active)
	begin
		active <= (remain > step);
		remain <= remain - step;
	end

	// Frame shifter, ones fill from the bottom so an idle line reads high
	always_ff @(posedge i_clk)
	if (i_reset)
		sreg <= '1;
	else if (i_start)
		sreg <= {1'b0, i_cmd, i_arg, crc7_40({1'b0, i_cmd, i_arg}), 1'b1};
	else if (i_ckstb)
	begin
		if (dbl)
			sreg <= {sreg[45:0], 2'b11};
		else
			sreg <= {sreg[46:0], 1'b1};
	end

	// Final step goes out this strobe
	assign o_last = active && i_ckstb && (remain == step);

	assign o_active   = active;
	assign o_cmd_en   = active;
	assign o_cmd_data = sreg[47:46];

endmodule

// ==== source/cmd_rx.sv ====
// Short response receiver with CRC7, framing check and a silent-line timeout
// All state drops while i_listen is low; o_resp and o_arg hold until reloaded
// Strobe bit 0 is honoured only together with strobe bit 1
module cmd_rx #(
	parameter int LGTIMEOUT = 26
) (
	input  logic         i_clk,
	input  logic         i_reset,
	input  logic         i_listen,
	input  logic [1:0]   i_cmd_strb,
	input  logic [1:0]   i_cmd_data,
	output logic         o_cmd_response,
	output logic [5:0]   o_resp,
	output logic [31:0]  o_arg,
	cmd_status_if.report st
);
	import sd_cmd_pkg::*;

	localparam logic [5:0] LAST_BIT = 6'(FRAME_BITS);
	localparam logic [5:0] CRC_SPAN = 6'd40;

	logic [5:0]           count;
	logic [5:0]           count_nxt;
	logic                 take1;
	logic                 take0;
	logic                 at_end;
	resp_word_u           sreg;
	resp_word_u           nxt;
	logic [6:0]           crc_fill;
	logic [6:0]           crc_nxt;
	logic [LGTIMEOUT-1:0] timer;
	logic                 end_q;

	////////////////////////////////////////////////////////////////////////////
	//
	// Bit capture
	//
	////////////////////////////////////////////////////////////////////////////

	// Earlier bit first, nothing past the 48th
	assign take1 = i_listen && i_cmd_strb[1] && (count < LAST_BIT);
	assign take0 = take1 && i_cmd_strb[0] && (count < LAST_BIT - 6'd1);
	assign count_nxt = count + {5'd0, take1} + {5'd0, take0};
	assign at_end = take1 && (count_nxt == LAST_BIT);

	// Next shift word and running CRC
	always_comb
	begin
		nxt = sreg;
		crc_nxt = crc_fill;
		if (take1)
		begin
			nxt.raw = {sreg.raw[46:0], i_cmd_data[1]};
			// CRC covers start through argument only
			if (count < CRC_SPAN)
				crc_nxt = crc7_step(crc_nxt, i_cmd_data[1]);
		end
		if (take0)
		begin
			nxt.raw = {nxt.raw[46:0], i_cmd_data[0]};
			if (count < CRC_SPAN - 6'd1)
				crc_nxt = crc7_step(crc_nxt, i_cmd_data[0]);
		end
	end

	always_ff @(posedge i_clk)
	if (i_reset || !i_listen)
	begin
		count    <= 6'd0;
		sreg.raw <= '0;
		crc_fill <= 7'h00;
	end else begin
		count    <= count_nxt;
		sreg     <= nxt;
		crc_fill <= crc_nxt;
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Timeout
	//
	////////////////////////////////////////////////////////////////////////////

	// Any strobe restarts the count
	always_ff @(posedge i_clk)
	if (i_reset || !i_listen || (i_cmd_strb != 2'b00))
		timer <= '1;
	else if (timer != '0)
		timer <= timer - 1'b1;

	// Fires once, when the counter steps to zero short of a full frame
	always_ff @(posedge i_clk)
	if (i_reset || !i_listen)
	begin
		end_q        <= 1'b0;
		st.timed_out <= 1'b0;
	end else begin
		end_q        <= at_end;
		st.timed_out <= (i_cmd_strb == 2'b00) && (timer == LGTIMEOUT'(1))
				&& (count < LAST_BIT);
	end

	////////////////////////////////////////////////////////////////////////////
	//
	// Decode and checks
	//
	////////////////////////////////////////////////////////////////////////////

	// CRC span completed several strobes earlier, crc_fill is final here
	always_ff @(posedge i_clk)
	if (at_end)
	begin
		o_resp       <= nxt.f.index;
		o_arg        <= nxt.f.arg;
		st.crc_bad   <= (crc_fill != nxt.f.crc);
		st.frame_bad <= nxt.f.start || nxt.f.transmission || !nxt.f.stop;
	end

	assign st.resp_end    = end_q;
	assign o_cmd_response = end_q;

endmodule

// ==== source/cmd_ctrl.sv ====
// Request handshake, response wait and completion code
// Requests are taken only on i_ckstb cycles; o_done ends every command
module cmd_ctrl (
	input  logic        i_clk,
	input  logic        i_reset,
	input  logic        i_ckstb,
	input  logic        i_cmd_request,
	input  logic [1:0]  i_cmd_type,
	input  logic        i_tx_last,
	input  logic        i_tx_active,
	cmd_status_if.judge st,
	output logic        o_start,
	output logic        o_listen,
	output logic        o_busy,
	output logic        o_done,
	output logic        o_err,
	output logic [1:0]  o_ercode
);
	import sd_cmd_pkg::*;

	logic accept;
	logic r_busy;
	logic resp_r1;
	logic done_now;
	logic wait_stb;

	assign accept  = i_cmd_request && !o_busy;
	assign o_start = accept;
	assign o_busy  = r_busy || !i_ckstb;

	// Busy from acceptance through the done cycle
	always_ff @(posedge i_clk)
	if (i_reset)
	begin
		r_busy  <= 1'b0;
		resp_r1 <= 1'b0;
	end else if (accept)
	begin
		r_busy  <= 1'b1;
		resp_r1 <= (i_cmd_type != RT_NONE);
	end else if (o_done)
		r_busy <= 1'b0;

	// Receiver runs once the frame is out
	assign o_listen = r_busy && resp_r1 && !i_tx_active;

	// Frame end without response, or a silent card, finish a cycle later
	always_ff @(posedge i_clk)
	if (i_reset)
		done_now <= 1'b0;
	else
		done_now <= (i_tx_last && !resp_r1) || (r_busy && st.timed_out);

	// Response seen, hold for the next clock enable
	always_ff @(posedge i_clk)
	if (i_reset || accept)
		wait_stb <= 1'b0;
	else if (st.resp_end && r_busy && !o_done)
		wait_stb <= 1'b1;
	else if (i_ckstb)
		wait_stb <= 1'b0;

	assign o_done = done_now || (wait_stb && i_ckstb);

	// Timeout first, then CRC over framing
	always_ff @(posedge i_clk)
	if (i_reset || accept)
	begin
		o_err    <= 1'b0;
		o_ercode <= EC_OKAY;
	end else if (r_busy && !o_done)
	begin
		if (st.timed_out)
		begin
			o_err    <= 1'b1;
			o_ercode <= EC_TIMEOUT;
		end else if (st.resp_end)
		begin
			o_err    <= st.crc_bad || st.frame_bad;
			o_ercode <= st.crc_bad ? EC_BADCRC : (st.frame_bad ? EC_FRAMEERR : EC_OKAY);
		end
	end

endmodule

// ==== source/sd_cmd.sv ====
// SD command-line engine, send a 48-bit command and take an optional R1 response
// LGTIMEOUT sets the silent-line limit as 2^LGTIMEOUT clocks
// Long R2 responses are not handled
module sd_cmd #(
	parameter int LGTIMEOUT = 26
) (
	input  logic        i_clk,
	input  logic        i_reset,
	input  logic        i_cfg_dbl,
	input  logic        i_ckstb,
	input  logic        i_cmd_request,
	input  logic [1:0]  i_cmd_type,
	input  logic [6:0]  i_cmd,
	input  logic [31:0] i_arg,
	input  logic [1:0]  i_cmd_strb,
	input  logic [1:0]  i_cmd_data,
	output logic        o_busy,
	output logic        o_done,
	output logic        o_err,
	output logic [1:0]  o_ercode,
	output logic        o_cmd_en,
	output logic [1:0]  o_cmd_data,
	output logic        o_cmd_response,
	output logic [5:0]  o_resp,
	output logic [31:0] o_arg
);

	// Sequencer to transmitter and receiver
	logic start;
	logic listen;

	// Transmitter back to sequencer
	logic tx_last;
	logic tx_active;

	// Receiver report
	cmd_status_if status ();

	cmd_ctrl u_ctrl (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_ckstb       (i_ckstb),
		.i_cmd_request (i_cmd_request),
		.i_cmd_type    (i_cmd_type),
		.i_tx_last     (tx_last),
		.i_tx_active   (tx_active),
		.st            (status.judge),
		.o_start       (start),
		.o_listen      (listen),
		.o_busy        (o_busy),
		.o_done        (o_done),
		.o_err         (o_err),
		.o_ercode      (o_ercode)
	);

	cmd_tx u_tx (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_ckstb    (i_ckstb),
		.i_start    (start),
		.i_cfg_dbl  (i_cfg_dbl),
		.i_cmd      (i_cmd),
		.i_arg      (i_arg),
		.o_cmd_en   (o_cmd_en),
		.o_cmd_data (o_cmd_data),
		.o_last     (tx_last),
		.o_active   (tx_active)
	);

	cmd_rx #(
		.LGTIMEOUT (LGTIMEOUT)
	) u_rx (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_listen       (listen),
		.i_cmd_strb     (i_cmd_strb),
		.i_cmd_data     (i_cmd_data),
		.o_cmd_response (o_cmd_response),
		.o_resp         (o_resp),
		.o_arg          (o_arg),
		.st             (status.report)
	);

endmodule

// ==== dv/sd_cmd_assert.sv ====
// Protocol checks bound into the engine top level
// Checks are disabled while i_reset is high
module sd_cmd_assert (
	input logic       i_clk,
	input logic       i_reset,
	input logic       i_ckstb,
	input logic       o_done,
	input logic       o_err,
	input logic [1:0] o_ercode,
	input logic       o_cmd_en,
	input logic [1:0] o_cmd_data,
	input logic       o_cmd_response
);
	import sd_cmd_pkg::*;

	// Single-cycle completion
	a_done_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
		o_done |=> !o_done) else $error("o_done held past one cycle");

	// Error flag only with a failing code
	a_err_code: assert property (@(posedge i_clk) disable iff (i_reset)
		o_err |-> (o_ercode != EC_OKAY)) else $error("o_err with EC_OKAY");

	// Line frozen without a clock enable
	a_tx_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		!i_ckstb |=> ($stable(o_cmd_en) && $stable(o_cmd_data)))
		else $error("CMD line moved without i_ckstb");

	a_resp_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
		o_cmd_response |=> !o_cmd_response) else $error("o_cmd_response held");

endmodule

bind sd_cmd sd_cmd_assert u_assert (
	.i_clk          (i_clk),
	.i_reset        (i_reset),
	.i_ckstb        (i_ckstb),
	.o_done         (o_done),
	.o_err          (o_err),
	.o_ercode       (o_ercode),
	.o_cmd_en       (o_cmd_en),
	.o_cmd_data     (o_cmd_data),
	.o_cmd_response (o_cmd_response)
);

// ==== dv/sd_cmd_tb.sv ====
// Random SD command traffic checked against a card model with LGTIMEOUT at 6
// Watchdog allows 400 cycles per command
module sd_cmd_tb;
	import sd_cmd_pkg::*;

	localparam int          PERIOD   = 40;
	localparam int          NUM_CMDS = 60;
	localparam int          CMD_CYC  = 400;
	localparam int          NBITS    = 48;
	localparam logic [31:0] SEED     = 32'hd91b6616;

	logic        i_clk;
	logic        i_reset;
	logic        i_cfg_dbl;
	logic        i_ckstb;
	logic        i_cmd_request;
	logic [1:0]  i_cmd_type;
	logic [6:0]  i_cmd;
	logic [31:0] i_arg;
	logic [1:0]  i_cmd_strb;
	logic [1:0]  i_cmd_data;
	logic        o_busy;
	logic        o_done;
	logic        o_err;
	logic [1:0]  o_ercode;
	logic        o_cmd_en;
	logic [1:0]  o_cmd_data;
	logic        o_cmd_response;
	logic [5:0]  o_resp;
	logic [31:0] o_arg;
	int          resp_pulses;

	sd_cmd #(.LGTIMEOUT(6)) uut (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #(PERIOD / 2) i_clk = ~i_clk;
	end

	// Clock enable high about 3 cycles in 4
	always @(posedge i_clk)
		i_ckstb <= ($urandom % 4) != 0;

	// Count response pulses per command
	always @(negedge i_clk)
		if (o_cmd_response)
			resp_pulses++;

	////////////////////////////////////////////////////////////////////////////
	// Reporting and compare helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_frame(input string name, input resp_word_u exp, input resp_word_u act);
		if (act !== exp)
			abort_run($sformatf("error %s: expected %h, actual %h", name, exp.raw, act.raw));
	endtask

	task automatic check_code(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
			abort_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_index(input string name, input logic [5:0] exp, input logic [5:0] act);
		if (act !== exp)
			abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_arg(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
	endtask

	// Remainder of msg * x^7 divided by x^7 + x^3 + 1
	function automatic logic [6:0] model_crc7(input logic [39:0] msg);
		logic [46:0] rem;
		rem = {msg, 7'd0};
		for (int i = 46; i >= 7; i--)
			if (rem[i])
				rem[i -: 8] = rem[i -: 8] ^ 8'h89;
		return rem[6:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Card model and command sequence
	////////////////////////////////////////////////////////////////////////////

	// One or two bits per strobe with short random gaps
	task automatic send_response(input resp_word_u resp);
		int   pos;
		int   gap;
		logic two;
		pos = NBITS - 1;
		while (pos >= 0)
		begin
			gap = int'($urandom % 5);
			repeat (gap)
			begin
				@(posedge i_clk);
				i_cmd_strb <= 2'b00;
			end
			two = (pos > 0) && (($urandom % 2) != 0);
			@(posedge i_clk);
			if (two)
			begin
				i_cmd_strb <= 2'b11;
				i_cmd_data <= {resp.raw[pos], resp.raw[pos-1]};
				pos -= 2;
			end else begin
				i_cmd_strb <= 2'b10;
				i_cmd_data <= {resp.raw[pos], 1'($urandom)};
				pos -= 1;
			end
		end
		@(posedge i_clk);
		i_cmd_strb <= 2'b00;
		i_cmd_data <= 2'b11;
		@(negedge i_clk);
	endtask

	// Modes 0,1 clean; 2 crc; 3 crc and stop; 4 start; 5 transmission; 6 stop; 7 silent
	task automatic run_command(input int n);
		string       name;
		logic        dbl;
		logic [1:0]  rtype;
		logic [6:0]  cmd_v;
		logic [31:0] arg_v;
		int          mode;
		int          taken;
		logic [1:0]  exp_code;
		resp_word_u  sent;
		resp_word_u  got;
		resp_word_u  resp;

		name  = $sformatf("cmd%0d", n);
		dbl   = 1'($urandom);
		rtype = 2'($urandom);
		cmd_v = 7'($urandom);
		arg_v = $urandom;
		mode  = int'($urandom % 8);
		sent.raw = {1'b0, cmd_v, arg_v, model_crc7({1'b0, cmd_v, arg_v}), 1'b1};

		// Line must rest high between commands
		@(negedge i_clk);
		if (o_cmd_en !== 1'b0 || o_cmd_data !== 2'b11)
			abort_run("CMD line not idle before a request");
		// Idle engine reports busy only without a clock enable
		check_flag({name, " idle busy"}, !i_ckstb, o_busy);

		@(posedge i_clk);
		i_cmd_request <= 1'b1;
		i_cmd         <= cmd_v;
		i_arg         <= arg_v;
		i_cmd_type    <= rtype;
		i_cfg_dbl     <= dbl;
		@(negedge i_clk);
		while (o_busy)
			@(negedge i_clk);
		// Accepted on this edge
		@(posedge i_clk);
		i_cmd_request <= 1'b0;
		resp_pulses = 0;

		@(negedge i_clk);
		if (!o_cmd_en)
			abort_run("o_cmd_en did not rise the cycle after acceptance");
		got.raw = '1;
		taken = 0;
		while (taken < NBITS)
		begin
			check_flag({name, " busy"}, 1'b1, o_busy);
			check_flag({name, " early done"}, 1'b0, o_done);
			if (o_cmd_en && i_ckstb)
			begin
				got.raw = {got.raw[46:0], o_cmd_data[1]};
				taken++;
				if (dbl)
				begin
					got.raw = {got.raw[46:0], o_cmd_data[0]};
					taken++;
				end
			end
			if (taken < NBITS)
				@(negedge i_clk);
		end
		check_frame({name, " frame"}, sent, got);

		@(negedge i_clk);
		if (o_cmd_en !== 1'b0 || o_cmd_data !== 2'b11)
			abort_run("CMD line still driven after the end bit");
		// No response expected, done one cycle after the final step
		if (rtype == RT_NONE)
			check_flag({name, " done after frame"}, 1'b1, o_done);

		// Card echoes the command index with a random status
		resp.raw            = '0;
		resp.f.index        = cmd_v[5:0];
		resp.f.arg          = $urandom;
		resp.f.start        = (mode == 4);
		resp.f.transmission = (mode == 5);
		resp.f.crc          = model_crc7(resp.raw[47:8]);
		if (mode == 2 || mode == 3)
			resp.f.crc = resp.f.crc ^ 7'(1 << ($urandom % 7));
		resp.f.stop = !(mode == 3 || mode == 6);

		if (rtype == RT_NONE)
			exp_code = EC_OKAY;
		else if (mode == 7)
			exp_code = EC_TIMEOUT;
		else if (mode == 2 || mode == 3)
			exp_code = EC_BADCRC;
		else if (mode >= 4)
			exp_code = EC_FRAMEERR;
		else
			exp_code = EC_OKAY;

		if (rtype != RT_NONE && mode != 7)
			send_response(resp);

		while (!o_done)
			@(negedge i_clk);
		check_flag({name, " done busy"}, 1'b1, o_busy);
		check_code({name, " ercode"}, exp_code, o_ercode);
		check_flag({name, " err"}, exp_code != EC_OKAY, o_err);
		if (rtype != RT_NONE && mode != 7)
		begin
			if (resp_pulses != 1)
				abort_run("o_cmd_response did not pulse once for a response");
			check_index({name, " index"}, resp.f.index, o_resp);
			check_arg({name, " arg"}, resp.f.arg, o_arg);
		end else if (resp_pulses != 0)
			abort_run("o_cmd_response pulsed with no response on the line");
	endtask

	initial
	begin
		void'($urandom(SEED));
		i_reset       = 1'b1;
		i_cfg_dbl     = 1'b0;
		i_ckstb       = 1'b0;
		i_cmd_request = 1'b0;
		i_cmd_type    = RT_NONE;
		i_cmd         = '0;
		i_arg         = '0;
		i_cmd_strb    = 2'b00;
		i_cmd_data    = 2'b11;
		resp_pulses   = 0;
		repeat (3) @(posedge i_clk);
		i_reset <= 1'b0;
		for (int n = 0; n < NUM_CMDS; n++)
			run_command(n);
		repeat (4) @(posedge i_clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

	// Run length bound
	initial
	begin
		#(PERIOD * CMD_CYC * NUM_CMDS);
		abort_run("Watchdog expired before all commands completed");
	end

endmodule

// ==== sd_cmd.f ====
source/sd_cmd_pkg.sv
source/cmd_status_if.sv
source/cmd_tx.sv
source/cmd_rx.sv
source/cmd_ctrl.sv
source/sd_cmd.sv
dv/sd_cmd_assert.sv
dv/sd_cmd_tb.sv

// ==== Makefile ====
# Verilator build and run for the SD command-line engine

VERILATOR ?= verilator
TOP       := sd_cmd_tb
FILELIST  := sd_cmd.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv) $(wildcard dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
